//--- Bender.yml
package:
  name: sifh

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/sifhPkg.sv
      - logic/histRam.sv
      - logic/sampleRouter.sv
      - logic/hisBuilder.sv
      - logic/peakMerger.sv
      - logic/sifhTop.sv

  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tbSifh.sv

//--- include/sifh_consts.svh
`ifndef SIFH_CONSTS_SVH
`define SIFH_CONSTS_SVH

// sizes of the histogram array
// all of them are powers of two so the index types stay exact

// time bins in one pixel histogram
`define BIN_NUM 16

// pixels in the whole sensor array
`define PIXEL_NUM 8

// width of one histogram count word
// counts saturate at all ones
`define COUNT_W 8

// pixels per bank
// even pixels go to bank 0, odd ones to bank 1
`define BANK_PIXELS (`PIXEL_NUM / 2)

// one bank RAM holds BANK_PIXELS histograms of BIN_NUM words,
// addressed as {local pixel, bin}

`endif

//--- list.f
+incdir+include
logic/sifhPkg.sv
logic/histRam.sv
logic/sampleRouter.sv
logic/hisBuilder.sv
logic/peakMerger.sv
logic/sifhTop.sv
sim/tbSifh.sv

//--- logic/hisBuilder.sv
`include "sifh_consts.svh"

// histogram builder of one bank
// clears its RAM, counts samples, then scans every pixel for its peak
module hisBuilder import sifhPkg::*; (
    input  logic     clk,
    input  logic     res,

    // samples from the router
    input  logic     bankReq,
    input  localPix  bankPix,
    input  binIdx    bankBin,
    input  logic     bankLast,
    output logic     bankAck,

    // count RAM
    output ramAddr   rAddr,
    output ramAddr   wAddr,
    output logic     wEn,
    output countWord wData,
    input  countWord rData,

    // peak records to the merger
    output logic     pkReq,
    output localPix  pkPix,
    output binIdx    pkBin,
    output countWord pkCount,
    input  logic     pkAck
);

    typedef enum logic [2:0] {CLEAR, COUNT, SCAN, DRAIN, OUT, OWAIT, FIN} builderState;

    builderState state;

    // sweep address of the initial clear
    logic [$bits(ramAddr)-1:0] clrCnt;

    // read pipeline
    // stage a holds the address on rAddr
    // stage b sees the data on rData
    logic     aValid;
    logic     bValid;
    ramAddr   bAddr;

    // the write that went into the RAM on the last edge
    logic     prevValid;
    ramAddr   prevAddr;
    countWord prevData;

    // count update of stage b
    countWord oldCount;
    countWord newCount;

    // running peak of the pixel being scanned
    countWord maxCount;
    binIdx    maxBin;

    // newest value of the stage b word
    // first the write still waiting in the port registers, then the one just
    // committed, which the read-first RAM did not return
    always_comb begin
        if (wEn && wAddr == bAddr) begin
            oldCount = wData;
        end else if (prevValid && prevAddr == bAddr) begin
            oldCount = prevData;
        end else begin
            oldCount = rData;
        end
        // saturate at all ones
        newCount = (oldCount == '1) ? oldCount : oldCount + 1'b1;
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= CLEAR;
            clrCnt    <= '0;
            aValid    <= 1'b0;
            bValid    <= 1'b0;
            prevValid <= 1'b0;
            wEn       <= 1'b0;
            bankAck   <= 1'b0;
            pkReq     <= 1'b0;
        end else begin
            bValid    <= aValid;
            prevValid <= wEn;
            wEn       <= 1'b0;
            case (state)
                CLEAR: begin
                    // one zero word per cycle
                    wEn    <= 1'b1;
                    clrCnt <= clrCnt + 1'b1;
                    if (clrCnt == ADDR_NUM - 1) begin
                        state <= COUNT;
                    end
                end
                COUNT: begin
                    // stage b writes its incremented word
                    wEn <= bValid;
                    if (aValid) begin
                        // read issued so ack while the write is still ahead
                        aValid  <= 1'b0;
                        bankAck <= 1'b1;
                    end else if (bankAck && !bankReq) begin
                        bankAck <= 1'b0;
                    end else if (bankReq && !bankAck && !bankLast) begin
                        aValid <= 1'b1;
                    end else if (bankReq && !bankAck && !bValid && !wEn) begin
                        // a marker starts the scan once nothing is pending
                        aValid <= 1'b1;
                        state  <= SCAN;
                    end
                end
                SCAN: begin
                    // zero written behind the read
                    wEn <= bValid;
                    if (rAddr.bin == binIdx'(`BIN_NUM - 1)) begin
                        aValid <= 1'b0;
                        state  <= DRAIN;
                    end
                end
                DRAIN: begin
                    // last bin of the pixel in stage b
                    wEn   <= bValid;
                    pkReq <= 1'b1;
                    state <= OUT;
                end
                OUT: begin
                    if (pkAck) begin
                        pkReq <= 1'b0;
                        state <= OWAIT;
                    end
                end
                OWAIT: begin
                    // scan waits here while the merger holds pkAck
                    if (!pkAck) begin
                        if (rAddr.pix == localPix'(`BANK_PIXELS - 1)) begin
                            bankAck <= 1'b1;
                            state   <= FIN;
                        end else begin
                            aValid <= 1'b1;
                            state  <= SCAN;
                        end
                    end
                end
                FIN: begin
                    // marker ack marks the whole bank as scanned
                    if (!bankReq) begin
                        bankAck <= 1'b0;
                        state   <= COUNT;
                    end
                end
                default: state <= CLEAR;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        bAddr    <= rAddr;
        prevAddr <= wAddr;
        prevData <= wData;
        case (state)
            CLEAR: begin
                wAddr <= ramAddr'(clrCnt);
                wData <= '0;
            end
            COUNT: begin
                wAddr    <= bAddr;
                wData    <= newCount;
                maxCount <= '0;
                maxBin   <= '0;
                // a marker starts the scan at pixel 0 and bin 0
                if (bankReq && !bankAck && !aValid) begin
                    rAddr.pix <= bankLast ? localPix'(0) : bankPix;
                    rAddr.bin <= bankLast ? binIdx'(0) : bankBin;
                end
            end
            SCAN, DRAIN: begin
                wAddr <= bAddr;
                wData <= '0;
                // strict compare keeps the lower bin on a tie
                if (bValid && rData > maxCount) begin
                    maxCount <= rData;
                    maxBin   <= bAddr.bin;
                end
                // wraps back to bin 0 after the last one
                if (state == SCAN) begin
                    rAddr.bin <= rAddr.bin + 1'b1;
                end
            end
            OWAIT: begin
                maxCount <= '0;
                maxBin   <= '0;
                if (!pkAck) begin
                    rAddr.pix <= rAddr.pix + 1'b1;
                end
            end
            default: ;
        endcase
    end

    // record straight from the peak registers
    assign pkPix   = rAddr.pix;
    assign pkBin   = maxBin;
    assign pkCount = maxCount;

endmodule

//--- logic/histRam.sv
// count memory of one bank
// simple dual port RAM with one write port and one registered read port
module histRam import sifhPkg::*; (
    input  logic     clk,

    // write port
    input  logic     wEn,
    input  ramAddr   wAddr,
    input  countWord wData,

    // read port with data one cycle after the address
    input  ramAddr   rAddr,
    output countWord rData
);

    // one word per pixel and bin
    countWord mem [ADDR_NUM];

    // write side
    always_ff @(posedge clk) begin
        if (wEn) begin
            mem[wAddr] <= wData;
        end
    end

    // read side
    // a read at the address being written returns the old word
    // the builder forwards around that
    always_ff @(posedge clk) begin
        rData <= mem[rAddr];
    end

endmodule

//--- logic/peakMerger.sv
// merges the peak records of both banks into one stream in pixel order
module peakMerger import sifhPkg::*; (
    input  logic     clk,
    input  logic     res,

    // records from the two builders
    input  logic     pkReq [2],
    input  localPix  pkPix [2],
    input  binIdx    pkBin [2],
    input  countWord pkCount [2],
    output logic     pkAck [2],

    // merged output, four phase
    output logic     peakReq,
    output pixelIdx  peakPixel,
    output binIdx    peakBin,
    output countWord peakCount,
    input  logic     peakAck
);

    typedef enum logic [1:0] {TAKE, PUSH, PWAIT} mergeState;

    mergeState state;
    // bank whose record comes next
    logic      turn;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state    <= TAKE;
            turn     <= 1'b0;
            pkAck[0] <= 1'b0;
            pkAck[1] <= 1'b0;
            peakReq  <= 1'b0;
        end else begin
            case (state)
                TAKE: begin
                    // the other bank waits even if it is ready first
                    if (pkReq[turn]) begin
                        pkAck[turn] <= 1'b1;
                        peakReq     <= 1'b1;
                        state       <= PUSH;
                    end
                end
                PUSH: begin
                    if (peakAck) begin
                        peakReq <= 1'b0;
                        state   <= PWAIT;
                    end
                end
                PWAIT: begin
                    // bank released only after the record is out
                    if (!peakAck && !pkReq[turn]) begin
                        pkAck[turn] <= 1'b0;
                        turn        <= ~turn;
                        state       <= TAKE;
                    end
                end
                default: state <= TAKE;
            endcase
        end
    end

    // holding register
    // global pixel is local index with the bank as low bit
    always_ff @(posedge clk) begin
        if (state == TAKE && pkReq[turn]) begin
            peakPixel <= {pkPix[turn], turn};
            peakBin   <= pkBin[turn];
            peakCount <= pkCount[turn];
        end
    end

endmodule

//--- logic/sampleRouter.sv
// splits the sample stream into the two banks by pixel parity
module sampleRouter import sifhPkg::*; (
    input  logic    clk,
    input  logic    res,

    // upstream samples over a four phase handshake
    input  logic    sampleReq,
    input  pixelIdx samplePixel,
    input  binIdx   sampleBin,
    input  logic    sampleLast,
    output logic    sampleAck,

    // one four phase channel per bank
    output logic    bankReq [2],
    output localPix bankPix [2],
    output binIdx   bankBin [2],
    output logic    bankLast [2],
    input  logic    bankAck [2]
);

    // SEND and SDROP carry the sample
    // MSEND and MDROP carry the end of frame markers
    typedef enum logic [2:0] {IDLE, SEND, SDROP, MSEND, MDROP, UPACK} routeState;

    routeState state;
    // target bank of the current sample
    logic      sel;
    logic      lastReg;
    // high while the markers are out
    logic      marker;
    localPix   pixReg;
    binIdx     binReg;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state      <= IDLE;
            sel        <= 1'b0;
            lastReg    <= 1'b0;
            marker     <= 1'b0;
            sampleAck  <= 1'b0;
            bankReq[0] <= 1'b0;
            bankReq[1] <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    // low pixel bit picks the bank
                    if (sampleReq) begin
                        sel                     <= samplePixel[0];
                        lastReg                 <= sampleLast;
                        bankReq[samplePixel[0]] <= 1'b1;
                        state                   <= SEND;
                    end
                end
                SEND: begin
                    if (bankAck[sel]) begin
                        bankReq[sel] <= 1'b0;
                        state        <= SDROP;
                    end
                end
                SDROP: begin
                    // sample counted so end the frame in both banks at once
                    // both must scan together or the merger would stall one of them
                    if (!bankAck[sel]) begin
                        if (lastReg) begin
                            marker     <= 1'b1;
                            bankReq[0] <= 1'b1;
                            bankReq[1] <= 1'b1;
                            state      <= MSEND;
                        end else begin
                            sampleAck <= 1'b1;
                            state     <= UPACK;
                        end
                    end
                end
                MSEND: begin
                    // each bank acks only after its scan is done
                    if (bankAck[0] && bankAck[1]) begin
                        bankReq[0] <= 1'b0;
                        bankReq[1] <= 1'b0;
                        state      <= MDROP;
                    end
                end
                MDROP: begin
                    if (!bankAck[0] && !bankAck[1]) begin
                        marker    <= 1'b0;
                        sampleAck <= 1'b1;
                        state     <= UPACK;
                    end
                end
                UPACK: begin
                    if (!sampleReq) begin
                        sampleAck <= 1'b0;
                        state     <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // sample fields with the parity bit stripped
    always_ff @(posedge clk) begin
        if (state == IDLE && sampleReq) begin
            pixReg <= samplePixel[$bits(pixelIdx)-1:1];
            binReg <= sampleBin;
        end
    end

    // same payload on both channels
    // only the req tells them apart
    always_comb begin
        for (int b = 0; b < 2; b++) begin
            bankPix[b]  = pixReg;
            bankBin[b]  = binReg;
            bankLast[b] = marker;
        end
    end

endmodule

//--- logic/sifhPkg.sv
`include "sifh_consts.svh"

// types shared by the router, the builders, the RAMs and the merger
package sifhPkg;

    // time bin inside one histogram
    typedef logic [$clog2(`BIN_NUM)-1:0] binIdx;

    // pixel number over the full array
    typedef logic [$clog2(`PIXEL_NUM)-1:0] pixelIdx;

    // pixel number inside one bank
    // the global index without its parity bit
    typedef logic [$clog2(`BANK_PIXELS)-1:0] localPix;

    // saturating hit counter
    typedef logic [`COUNT_W-1:0] countWord;

    // bank RAM address with the pixel in the upper bits
    typedef struct packed {
        localPix pix;
        binIdx   bin;
    } ramAddr;

    // words per bank RAM
    localparam int ADDR_NUM = `BANK_PIXELS * `BIN_NUM;

endpackage

//--- logic/sifhTop.sv
// per pixel time histogram peak finder, two banks side by side
module sifhTop import sifhPkg::*; (
    input  logic     clk,
    input  logic     res,

    // sample input
    input  logic     sampleReq,
    input  pixelIdx  samplePixel,
    input  binIdx    sampleBin,
    input  logic     sampleLast,
    output logic     sampleAck,

    // peak record output
    output logic     peakReq,
    output pixelIdx  peakPixel,
    output binIdx    peakBin,
    output countWord peakCount,
    input  logic     peakAck
);

    // router to builders
    logic     bankReq [2];
    localPix  bankPix [2];
    binIdx    bankBin [2];
    logic     bankLast [2];
    logic     bankAck [2];

    // builders to RAMs
    ramAddr   rAddr [2];
    ramAddr   wAddr [2];
    logic     wEn [2];
    countWord wData [2];
    countWord rData [2];

    // builders to merger
    logic     pkReq [2];
    localPix  pkPix [2];
    binIdx    pkBin [2];
    countWord pkCount [2];
    logic     pkAck [2];

    sampleRouter sampleRouter_inst (
        .clk(clk), .res(res),
        .sampleReq(sampleReq), .samplePixel(samplePixel),
        .sampleBin(sampleBin), .sampleLast(sampleLast), .sampleAck(sampleAck),
        .bankReq(bankReq), .bankPix(bankPix), .bankBin(bankBin),
        .bankLast(bankLast), .bankAck(bankAck)
    );

    // bank 0 even pixels, bank 1 odd pixels
    for (genvar b = 0; b < 2; b++) begin : bank
        hisBuilder hisBuilder_inst (
            .clk(clk), .res(res),
            .bankReq(bankReq[b]), .bankPix(bankPix[b]), .bankBin(bankBin[b]),
            .bankLast(bankLast[b]), .bankAck(bankAck[b]),
            .rAddr(rAddr[b]), .wAddr(wAddr[b]), .wEn(wEn[b]),
            .wData(wData[b]), .rData(rData[b]),
            .pkReq(pkReq[b]), .pkPix(pkPix[b]), .pkBin(pkBin[b]),
            .pkCount(pkCount[b]), .pkAck(pkAck[b])
        );

        histRam histRam_inst (
            .clk(clk),
            .wEn(wEn[b]), .wAddr(wAddr[b]), .wData(wData[b]),
            .rAddr(rAddr[b]), .rData(rData[b])
        );
    end

    peakMerger peakMerger_inst (
        .clk(clk), .res(res),
        .pkReq(pkReq), .pkPix(pkPix), .pkBin(pkBin),
        .pkCount(pkCount), .pkAck(pkAck),
        .peakReq(peakReq), .peakPixel(peakPixel), .peakBin(peakBin),
        .peakCount(peakCount), .peakAck(peakAck)
    );

endmodule

//--- sim/tbSifh.sv
`include "sifh_consts.svh"

// testbench for the two bank histogram peak finder
module tbSifh import sifhPkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    // each repeat of a table row is one four phase sample
    // last applies to the final repeat only
    typedef struct packed {
        logic [3:0] frame;
        pixelIdx    pix;
        binIdx      bin;
        logic [9:0] rep;
        logic       last;
    } stimEntry;

    localparam int STIM_NUM = 22;
    localparam int SAT_MAX = (1 << `COUNT_W) - 1;

    // frame 0 dominant bins and a tie on pixel 5
    // frame 1 saturation with back to back hits, a tie on pixel 6, empty pixels
    // frame 2 only the last sample
    // frame 3 same bin in both banks
    stimEntry stimTable [STIM_NUM] = '{
        '{4'd0, 3'd0, 4'd3,  10'd5,   1'b0},
        '{4'd0, 3'd0, 4'd7,  10'd2,   1'b0},
        '{4'd0, 3'd1, 4'd9,  10'd4,   1'b0},
        '{4'd0, 3'd2, 4'd0,  10'd3,   1'b0},
        '{4'd0, 3'd2, 4'd12, 10'd6,   1'b0},
        '{4'd0, 3'd3, 4'd15, 10'd7,   1'b0},
        '{4'd0, 3'd4, 4'd5,  10'd2,   1'b0},
        '{4'd0, 3'd5, 4'd8,  10'd3,   1'b0},
        '{4'd0, 3'd5, 4'd2,  10'd3,   1'b0},
        '{4'd0, 3'd6, 4'd11, 10'd1,   1'b0},
        '{4'd0, 3'd7, 4'd6,  10'd4,   1'b1},
        '{4'd1, 3'd3, 4'd10, 10'd300, 1'b0},
        '{4'd1, 3'd3, 4'd4,  10'd20,  1'b0},
        '{4'd1, 3'd6, 4'd13, 10'd2,   1'b0},
        '{4'd1, 3'd6, 4'd1,  10'd2,   1'b0},
        '{4'd1, 3'd1, 4'd0,  10'd1,   1'b1},
        '{4'd2, 3'd4, 4'd9,  10'd1,   1'b1},
        '{4'd3, 3'd0, 4'd1,  10'd3,   1'b0},
        '{4'd3, 3'd1, 4'd1,  10'd3,   1'b0},
        '{4'd3, 3'd0, 4'd1,  10'd2,   1'b0},
        '{4'd3, 3'd7, 4'd15, 10'd9,   1'b0},
        '{4'd3, 3'd2, 4'd14, 10'd1,   1'b1}
    };

    logic     clk = 1'b0;
    logic     res;
    logic     sampleReq;
    pixelIdx  samplePixel;
    binIdx    sampleBin;
    logic     sampleLast;
    logic     sampleAck;
    logic     peakReq;
    pixelIdx  peakPixel;
    binIdx    peakBin;
    countWord peakCount;
    logic     peakAck;

    // reference model of saturating hit counts per pixel and bin
    int       hits [`PIXEL_NUM][`BIN_NUM];
    binIdx    expBin [`PIXEL_NUM];
    countWord expCount [`PIXEL_NUM];

    // high only while a frame end is in progress
    bit       recvActive;
    // records whose four phase transfer has completed
    int       recordsSeen;

    always #2 clk = ~clk;

    sifhTop sifhTop_inst (
        .clk(clk), .res(res),
        .sampleReq(sampleReq), .samplePixel(samplePixel),
        .sampleBin(sampleBin), .sampleLast(sampleLast), .sampleAck(sampleAck),
        .peakReq(peakReq), .peakPixel(peakPixel), .peakBin(peakBin),
        .peakCount(peakCount), .peakAck(peakAck)
    );

    task automatic abortRun();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic checkPixel(input pixelIdx got, input pixelIdx exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: peakPixel got %0d expected %0d", $time, got, exp);
            abortRun();
        end
    endtask

    task automatic checkBin(input binIdx got, input binIdx exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: peakBin got %0d expected %0d", $time, got, exp);
            abortRun();
        end
    endtask

    task automatic checkCount(input countWord got, input countWord exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: peakCount got %0d expected %0d", $time, got, exp);
            abortRun();
        end
    endtask

    // both waits poll one ns after the edge
    task automatic waitSampleAck(input logic level, input int limit);
        int n;
        n = 0;
        while (sampleAck !== level) begin
            if (n == limit) begin
                $display("timeout: sampleAck never went to %0d", level);
                abortRun();
            end
            @(posedge clk);
            #1;
            n++;
        end
    endtask

    task automatic waitPeakReq(input logic level, input int limit);
        int n;
        n = 0;
        while (peakReq !== level) begin
            if (n == limit) begin
                $display("timeout: peakReq never went to %0d", level);
                abortRun();
            end
            @(posedge clk);
            #1;
            n++;
        end
    endtask

    function automatic void clearModel();
        foreach (hits[p, b]) begin
            hits[p][b] = 0;
        end
    endfunction

    function automatic void addHit(input pixelIdx pix, input binIdx bin);
        if (hits[pix][bin] < SAT_MAX) begin
            hits[pix][bin]++;
        end
    endfunction

    // largest count wins and a strict compare keeps the lower bin on a tie
    function automatic void derivePeaks();
        int best;
        for (int p = 0; p < `PIXEL_NUM; p++) begin
            best = 0;
            expBin[p] = '0;
            for (int b = 0; b < `BIN_NUM; b++) begin
                if (hits[p][b] > best) begin
                    best = hits[p][b];
                    expBin[p] = binIdx'(b);
                end
            end
            expCount[p] = countWord'(best);
        end
    endfunction

    // one complete four phase sample
    task automatic sendSample(input pixelIdx pix, input binIdx bin, input logic last,
                              input int limit);
        samplePixel = pix;
        sampleBin   = bin;
        sampleLast  = last;
        sampleReq   = 1'b1;
        waitSampleAck(1'b1, limit);
        // final ack only once the whole frame is out
        if (last && recordsSeen != `PIXEL_NUM) begin
            $display("sampleAck of the last sample came after only %0d records", recordsSeen);
            abortRun();
        end
        sampleReq = 1'b0;
        waitSampleAck(1'b0, 20);
    endtask

    // answers each record after 0 to 6 cycles
    task automatic receiveRecords();
        int delay;
        for (int k = 0; k < `PIXEL_NUM; k++) begin
            waitPeakReq(1'b1, 3000);
            checkPixel(peakPixel, pixelIdx'(k));
            checkBin(peakBin, expBin[k]);
            checkCount(peakCount, expCount[k]);
            delay = $urandom_range(0, 6);
            repeat (delay) begin
                @(posedge clk);
                #1;
            end
            peakAck = 1'b1;
            waitPeakReq(1'b0, 20);
            peakAck = 1'b0;
            recordsSeen++;
        end
    endtask

    // last sample and the eight records run side by side
    task automatic finishFrame(input pixelIdx pix, input binIdx bin, input int frame);
        derivePeaks();
        recordsSeen = 0;
        recvActive  = 1'b1;
        fork
            sendSample(pix, bin, 1'b1, 5000);
            receiveRecords();
        join
        recvActive = 1'b0;
        clearModel();
        $display("frame %0d: %0d records checked", frame, recordsSeen);
    endtask

    // no record may show up between frame ends
    always @(negedge clk) begin
        if (res && peakReq && !recvActive) begin
            $display("peakReq raised while no frame end was pending");
            abortRun();
        end
    end

    initial begin
        logic isLast;
        void'($urandom(32'h68ac));
        res         = 1'b0;
        sampleReq   = 1'b0;
        samplePixel = '0;
        sampleBin   = '0;
        sampleLast  = 1'b0;
        peakAck     = 1'b0;
        recvActive  = 1'b0;
        recordsSeen = 0;
        clearModel();
        repeat (2) @(posedge clk);
        #1;
        res = 1'b1;
        for (int i = 0; i < STIM_NUM; i++) begin
            for (int r = 0; r < stimTable[i].rep; r++) begin
                isLast = stimTable[i].last && (r == stimTable[i].rep - 1);
                // last sample counts too
                addHit(stimTable[i].pix, stimTable[i].bin);
                if (isLast) begin
                    finishFrame(stimTable[i].pix, stimTable[i].bin, stimTable[i].frame);
                end else begin
                    // first sample also waits out the initial clear
                    sendSample(stimTable[i].pix, stimTable[i].bin, 1'b0, 200);
                end
            end
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule
